// File: common/hb_pkg.sv
`default_nettype none

package hb_pkg;

   // ========================================
   // widths
   // ========================================

   // setpoint word sent to the modulation controller
   localparam int SP_W = 8;
   // dead-time run counter
   localparam int DT_W = 8;

   // ========================================
   // bundles
   // ========================================

   // operator panel, raw from the board or debounced
   typedef struct packed {
      logic enable;
      logic reset_angles;
      logic inc_phi;
      logic dec_phi;
      logic inc_delta;
   } panel_t;

   // four bridge gates, hs_leg1 sits in bit 0
   // leg 1 pair is Q1/Q3, leg 2 pair is Q2/Q4
   typedef struct packed {
      logic ls_leg2;
      logic ls_leg1;
      logic hs_leg2;
      logic hs_leg1;
   } gate_t;

   // setpoints for the external controller
   typedef struct packed {
      logic [SP_W-1:0] phi;
      logic [SP_W-1:0] delta;
   } setpoint_t;

   // start-up phases of the bridge
   typedef enum logic [1:0] {
      PH_OFF       = 2'd0,
      PH_BOOTSTRAP = 2'd1,
      PH_PRECHARGE = 2'd2,
      PH_RUN       = 2'd3
   } startup_phase_e;

   // board switch codes for the dead time
   typedef enum logic [1:0] {
      DT_00 = 2'b00,
      DT_01 = 2'b01,
      DT_10 = 2'b10,
      DT_11 = 2'b11
   } dt_sel_e;

   // turn-on delay in clock cycles, indexed by switch code
   // 00 -> 80, 01 -> 40, 10 -> 20, 11 -> 60
   localparam logic [DT_W-1:0] DEADTIME_TABLE [4] = '{8'd80, 8'd40, 8'd20, 8'd60};

endpackage

`default_nettype wire

// File: source/panel_debounce.sv
`timescale 1ns/1ps
`default_nettype none

module panel_debounce import hb_pkg::*; #(
   parameter int DEBOUNCE_CYCLES = 500000
) (
   input  logic   ADA_DCO,
   input  logic   i_reset,
   input  panel_t i_raw,
   output panel_t o_panel
);

   localparam int N_BITS = $bits(panel_t);
   localparam int CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);
   // last count before a change is committed
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

   logic [N_BITS-1:0] raw_bits;
   logic [N_BITS-1:0] held_bits;
   logic [CNT_W-1:0]  stable_cnt [N_BITS];

   // flatten the panel so each bit gets its own counter
   assign raw_bits = i_raw;

   // ========================================
   // per-bit stability counters
   // ========================================
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         held_bits <= '0;
         for (int b = 0; b < N_BITS; b++) begin
            stable_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < N_BITS; b++) begin
            if (raw_bits[b] == held_bits[b]) begin
               // bounce back to the held level, start over
               stable_cnt[b] <= '0;
            end else if (stable_cnt[b] == CNT_LAST) begin
               // long enough away from held value
               held_bits[b]  <= raw_bits[b];
               stable_cnt[b] <= '0;
            end else begin
               stable_cnt[b] <= stable_cnt[b] + 1'b1;
            end
         end
      end
   end

   assign o_panel = held_bits;

endmodule

`default_nettype wire

// File: setpoint/setpoint_register.sv
`timescale 1ns/1ps
`default_nettype none

module setpoint_register import hb_pkg::*; #(
   parameter int STEP    = 1,
   parameter int MIN_VAL = 0,
   parameter int MAX_VAL = 255
) (
   input  logic            ADA_DCO,
   input  logic            i_reset,
   input  logic            i_zero,
   input  logic            i_inc,
   input  logic            i_dec,
   output logic [SP_W-1:0] o_value
);

   // one extra bit so the bound checks cannot wrap
   localparam logic [SP_W:0]   STEP_X = (SP_W + 1)'(STEP);
   localparam logic [SP_W:0]   MIN_X  = (SP_W + 1)'(MIN_VAL);
   localparam logic [SP_W:0]   MAX_X  = (SP_W + 1)'(MAX_VAL);
   localparam logic [SP_W-1:0] STEP_V = SP_W'(STEP);
   localparam logic [SP_W-1:0] MIN_V  = SP_W'(MIN_VAL);
   localparam logic [SP_W-1:0] MAX_V  = SP_W'(MAX_VAL);

   logic          zero_q;
   logic          inc_q;
   logic          dec_q;
   logic          zero_rise;
   logic          inc_rise;
   logic          dec_rise;
   logic [SP_W:0] value_x;
   logic [SP_W:0] value_up;

   // rising edges of the debounced buttons
   assign zero_rise = i_zero & ~zero_q;
   assign inc_rise  = i_inc & ~inc_q;
   assign dec_rise  = i_dec & ~dec_q;

   assign value_x  = {1'b0, o_value};
   assign value_up = value_x + STEP_X;

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         zero_q  <= 1'b0;
         inc_q   <= 1'b0;
         dec_q   <= 1'b0;
         o_value <= MIN_V;
      end else begin
         zero_q <= i_zero;
         inc_q  <= i_inc;
         dec_q  <= i_dec;
         // zero has priority over both steps
         if (zero_rise) begin
            o_value <= MIN_V;
         end else if (inc_rise && !dec_rise) begin
            o_value <= (value_up > MAX_X) ? MAX_V : value_up[SP_W-1:0];
         end else if (dec_rise && !inc_rise) begin
            o_value <= (value_x < MIN_X + STEP_X) ? MIN_V : o_value - STEP_V;
         end
         // inc and dec together cancel out
      end
   end

endmodule

`default_nettype wire

// File: gate_path/startup_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module startup_sequencer import hb_pkg::*; #(
   parameter int ON_CYCLES = 1000,
   parameter int VG_CYCLES = 1600
) (
   input  logic           ADA_DCO,
   input  logic           i_reset,
   input  logic           i_enable,
   output startup_phase_e o_phase
);

   localparam int CNT_W = $clog2(VG_CYCLES + 2);
   // end of bootstrap charging
   localparam logic [CNT_W-1:0] CNT_ON   = CNT_W'(ON_CYCLES);
   // end of tank pre-charge
   localparam logic [CNT_W-1:0] CNT_VG   = CNT_W'(VG_CYCLES);
   // counter parks here while running
   localparam logic [CNT_W-1:0] CNT_STOP = CNT_W'(VG_CYCLES + 1);

   logic [CNT_W-1:0] cnt;

   // ========================================
   // enabled-cycle counter
   // ========================================
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         cnt <= '0;
      end else if (!i_enable) begin
         // bridge off, restart from scratch
         cnt <= '0;
      end else if (cnt != CNT_STOP) begin
         cnt <= cnt + 1'b1;
      end
   end

   // phase decode from the registered count
   always_comb begin
      if (cnt == '0) begin
         o_phase = PH_OFF;
      end else if (cnt <= CNT_ON) begin
         o_phase = PH_BOOTSTRAP;
      end else if (cnt <= CNT_VG) begin
         o_phase = PH_PRECHARGE;
      end else begin
         o_phase = PH_RUN;
      end
   end

endmodule

`default_nettype wire

// File: gate_path/dead_time.sv
`timescale 1ns/1ps
`default_nettype none

module dead_time import hb_pkg::*; (
   input  logic    ADA_DCO,
   input  logic    i_reset,
   input  gate_t   i_cmd,
   input  dt_sel_e i_dt_sel,
   output gate_t   o_gate
);

   localparam int N_GATES = $bits(gate_t);

   logic [N_GATES-1:0] cmd_bits;
   logic [N_GATES-1:0] out_bits;
   logic [DT_W-1:0]    sel_len;
   logic [DT_W-1:0]    run_cnt [N_GATES];
   logic [DT_W-1:0]    run_len [N_GATES];
   logic [DT_W-1:0]    target  [N_GATES];

   assign cmd_bits = i_cmd;
   // delay for the current switch code
   assign sel_len  = DEADTIME_TABLE[i_dt_sel];

   // first sample of a run uses the live table entry
   always_comb begin
      for (int g = 0; g < N_GATES; g++) begin
         target[g] = (run_cnt[g] == '0) ? sel_len : run_len[g];
      end
   end

   // delay length frozen at the start of each high run
   always_ff @(posedge ADA_DCO) begin
      for (int g = 0; g < N_GATES; g++) begin
         if (cmd_bits[g] && (run_cnt[g] == '0)) begin
            run_len[g] <= sel_len;
         end
      end
   end

   // ========================================
   // turn-on delay, turn-off passes through
   // ========================================
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         out_bits <= '0;
         for (int g = 0; g < N_GATES; g++) begin
            run_cnt[g] <= '0;
         end
      end else begin
         for (int g = 0; g < N_GATES; g++) begin
            if (!cmd_bits[g]) begin
               out_bits[g] <= 1'b0;
               run_cnt[g]  <= '0;
            end else if (!out_bits[g]) begin
               // count stays at target once the gate is on
               run_cnt[g] <= run_cnt[g] + 1'b1;
               if ((run_cnt[g] + 1'b1) >= target[g]) begin
                  out_bits[g] <= 1'b1;
               end
            end
         end
      end
   end

   assign o_gate = out_bits;

endmodule

`default_nettype wire

// File: gate_path/gate_driver.sv
`timescale 1ns/1ps
`default_nettype none

module gate_driver import hb_pkg::*; (
   input  logic           ADA_DCO,
   input  logic           i_reset,
   input  logic           i_enable,
   input  startup_phase_e i_phase,
   input  gate_t          i_gate,
   output gate_t          o_gate
);

   gate_t pattern;
   gate_t next_gate;
   logic  leg_short;

   // both switches of one leg on means shoot-through
   assign leg_short = (i_gate.hs_leg1 & i_gate.ls_leg1) |
                      (i_gate.hs_leg2 & i_gate.ls_leg2);

   // ========================================
   // pattern per start-up phase
   // ========================================
   always_comb begin
      pattern = '0;
      case (i_phase)
         PH_OFF: begin
            pattern = '0;
         end
         PH_BOOTSTRAP: begin
            // low sides on to charge the bootstrap caps
            pattern.ls_leg1 = 1'b1;
            pattern.ls_leg2 = 1'b1;
         end
         PH_PRECHARGE: begin
            // diagonal Q1/Q4 to pre-charge the tank
            pattern.hs_leg1 = 1'b1;
            pattern.ls_leg2 = 1'b1;
         end
         PH_RUN: begin
            pattern = i_gate;
         end
         default: begin
            pattern = '0;
         end
      endcase
   end

   // blank everything on a short or when disabled
   assign next_gate = (leg_short || !i_enable) ? gate_t'('0) : pattern;

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_gate <= '0;
      end else begin
         o_gate <= next_gate;
      end
   end

endmodule

`default_nettype wire

// File: source/hb_gate_top.sv
`timescale 1ns/1ps
`default_nettype none

module hb_gate_top import hb_pkg::*; #(
   // 5 ms at 100 MHz
   parameter int DEBOUNCE_CYCLES = 500000,
   // 10 us bootstrap charge
   parameter int ON_CYCLES       = 1000,
   // 16 us until normal run
   parameter int VG_CYCLES       = 1600
) (
   input  logic      ADA_DCO,
   input  logic      i_reset,
   input  panel_t    i_panel,
   input  gate_t     i_mosfet_cmd,
   input  dt_sel_e   i_dt_sel,
   output gate_t     o_gate,
   output setpoint_t o_setpoint
);

   panel_t          panel_db;
   gate_t           gate_dt;
   startup_phase_e  phase;
   logic [SP_W-1:0] phi_value;
   logic [SP_W-1:0] delta_value;

   // ========================================
   // operator panel
   // ========================================
   panel_debounce #(
      .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
   ) panel_debounce_i (
      .ADA_DCO (ADA_DCO),
      .i_reset (i_reset),
      .i_raw   (i_panel),
      .o_panel (panel_db)
   );

   // phi in steps of 5, 0 to 90
   setpoint_register #(
      .STEP    (5),
      .MIN_VAL (0),
      .MAX_VAL (90)
   ) phi_reg (
      .ADA_DCO (ADA_DCO),
      .i_reset (i_reset),
      .i_zero  (panel_db.reset_angles),
      .i_inc   (panel_db.inc_phi),
      .i_dec   (panel_db.dec_phi),
      .o_value (phi_value)
   );

   // zvs margin, increase only
   setpoint_register #(
      .STEP    (1),
      .MIN_VAL (0),
      .MAX_VAL (40)
   ) delta_reg (
      .ADA_DCO (ADA_DCO),
      .i_reset (i_reset),
      .i_zero  (1'b0),
      .i_inc   (panel_db.inc_delta),
      .i_dec   (1'b0),
      .o_value (delta_value)
   );

   assign o_setpoint = {phi_value, delta_value};

   // ========================================
   // gate path
   // ========================================
   startup_sequencer #(
      .ON_CYCLES (ON_CYCLES),
      .VG_CYCLES (VG_CYCLES)
   ) startup_sequencer_i (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_enable (panel_db.enable),
      .o_phase  (phase)
   );

   dead_time dead_time_i (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_cmd    (i_mosfet_cmd),
      .i_dt_sel (i_dt_sel),
      .o_gate   (gate_dt)
   );

   gate_driver gate_driver_i (
      .ADA_DCO  (ADA_DCO),
      .i_reset  (i_reset),
      .i_enable (panel_db.enable),
      .i_phase  (phase),
      .i_gate   (gate_dt),
      .o_gate   (o_gate)
   );

endmodule

`default_nettype wire

// File: tests/hb_gate_model.svh
`ifndef HB_GATE_MODEL_SVH
`define HB_GATE_MODEL_SVH

// ========================================
// reference model state
// ========================================

// debounced panel and the run of differing samples per bit
logic [4:0] db_held;
int         db_run [5];
// setpoints plus debounced buttons one cycle back
logic [7:0] phi_exp;
logic [7:0] delta_exp;
logic [4:0] btn_prev;
// enabled-cycle count of the start-up sequence
int         seq_cnt;
// consecutive high samples and frozen delay per gate
int         hi_run [4];
int         hi_len [4];
logic [3:0] dt_out;
// expected o_gate
logic [3:0] gate_exp;

// switch code to turn-on delay
function automatic int dead_time_cycles(input logic [1:0] sel);
   case (sel)
      2'b00: return 80;
      2'b10: return 20;
      2'b01: return 40;
      default: return 60;
   endcase
endfunction

// 0 off, 1 bootstrap, 2 pre-charge, 3 run
function automatic int phase_of(input int cnt);
   if (cnt == 0) begin
      return 0;
   end else if (cnt <= ON_CYCLES) begin
      return 1;
   end else if (cnt <= VG_CYCLES) begin
      return 2;
   end
   return 3;
endfunction

// one step up or down, clamped to 0..hi
function automatic logic [7:0] step_value(input logic [7:0] v, input int step, input int hi,
                                          input logic up);
   int nv;
   nv = up ? int'(v) + step : int'(v) - step;
   if (nv > hi) begin
      nv = hi;
   end
   if (nv < 0) begin
      nv = 0;
   end
   return 8'(nv);
endfunction

task automatic reset_reference();
   db_held   = '0;
   phi_exp   = '0;
   delta_exp = '0;
   btn_prev  = '0;
   seq_cnt   = 0;
   dt_out    = '0;
   gate_exp  = '0;
   for (int b = 0; b < 5; b++) begin
      db_run[b] = 0;
   end
   for (int g = 0; g < 4; g++) begin
      hi_run[g] = 0;
      hi_len[g] = 0;
   end
endtask

// one rising edge, every stage reads the state from before it
task automatic step_reference(input logic [4:0] raw, input logic [3:0] cmd,
                              input logic [1:0] sel);
   logic [4:0] rise;
   logic [3:0] pat;
   // gate driver pattern by phase
   case (phase_of(seq_cnt))
      1: pat = 4'b1100;
      2: pat = 4'b1001;
      3: pat = dt_out;
      default: pat = 4'b0000;
   endcase
   // blank on a leg short or while disabled
   if (!db_held[4] || (dt_out[0] && dt_out[2]) || (dt_out[1] && dt_out[3])) begin
      pat = 4'b0000;
   end
   gate_exp = pat;
   // setpoints move on debounced rising edges
   rise = db_held & ~btn_prev;
   if (rise[3]) begin
      phi_exp = '0;
   end else if (rise[2] && !rise[1]) begin
      phi_exp = step_value(phi_exp, 5, 90, 1'b1);
   end else if (rise[1] && !rise[2]) begin
      phi_exp = step_value(phi_exp, 5, 90, 1'b0);
   end
   if (rise[0]) begin
      delta_exp = step_value(delta_exp, 1, 40, 1'b1);
   end
   btn_prev = db_held;
   // start-up count parks one past VG_CYCLES
   if (!db_held[4]) begin
      seq_cnt = 0;
   end else if (seq_cnt < VG_CYCLES + 1) begin
      seq_cnt++;
   end
   // dead time, delay taken at the first high sample
   for (int g = 0; g < 4; g++) begin
      if (!cmd[g]) begin
         hi_run[g] = 0;
         dt_out[g] = 1'b0;
      end else begin
         hi_run[g]++;
         if (hi_run[g] == 1) begin
            hi_len[g] = dead_time_cycles(sel);
         end
         if (hi_run[g] >= hi_len[g]) begin
            dt_out[g] = 1'b1;
         end
      end
   end
   // debounce, commit after DEBOUNCE_CYCLES differing samples
   for (int b = 0; b < 5; b++) begin
      if (raw[b] != db_held[b]) begin
         db_run[b]++;
         if (db_run[b] == DEBOUNCE_CYCLES) begin
            db_held[b] = raw[b];
            db_run[b]  = 0;
         end
      end else begin
         db_run[b] = 0;
      end
   end
endtask

`endif

// File: tests/tb_hb_gate_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hb_gate_top import hb_pkg::*; ();

   localparam int DEBOUNCE_CYCLES = 4;
   localparam int ON_CYCLES       = 10;
   localparam int VG_CYCLES       = 16;
   // test lengths in clock cycles
   localparam int N_PRESSES   = 60;
   // enough presses to run delta from 0 to 40 and phi to 90
   localparam int N_SAT_PRESSES = 41;
   localparam int PRESS_MAX   = 12 * (DEBOUNCE_CYCLES - 1) + 6 * DEBOUNCE_CYCLES;
   localparam int STARTUP_LEN = DEBOUNCE_CYCLES + VG_CYCLES + 20;
   localparam int DT_LEN      = 3000;
   localparam int SHORT_LEN   = 100;
   localparam int TOTAL_CYCLES = 8 + 40 + (N_PRESSES + N_SAT_PRESSES) * PRESS_MAX +
                                 2 * STARTUP_LEN + DT_LEN + 9 * SHORT_LEN +
                                 3 * DEBOUNCE_CYCLES + 6 * DEBOUNCE_CYCLES;
   // twice the test length plus margin, 10 ns per cycle
   localparam int TIMEOUT_NS = (2 * TOTAL_CYCLES + 500) * 10;

   logic      ADA_DCO;
   logic      i_reset;
   panel_t    i_panel;
   gate_t     i_mosfet_cmd;
   dt_sel_e   i_dt_sel;
   gate_t     o_gate;
   setpoint_t o_setpoint;

   integer      seed;
   logic [31:0] rnd;
   string       test_name;

`include "hb_gate_model.svh"

   hb_gate_top #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
      .ON_CYCLES       (ON_CYCLES),
      .VG_CYCLES       (VG_CYCLES)
   ) hb_gate_top_i (
      .ADA_DCO      (ADA_DCO),
      .i_reset      (i_reset),
      .i_panel      (i_panel),
      .i_mosfet_cmd (i_mosfet_cmd),
      .i_dt_sel     (i_dt_sel),
      .o_gate       (o_gate),
      .o_setpoint   (o_setpoint)
   );

   // 100 MHz
   always #5 ADA_DCO = ~ADA_DCO;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "testbench stopped on error");
   endtask

   task automatic check_outputs();
      assert (o_gate === gate_exp) else
         fail_run($sformatf("Mismatch %s o_gate: expected %b actual %b",
                            test_name, gate_exp, o_gate));
      assert (o_setpoint === {phi_exp, delta_exp}) else
         fail_run($sformatf("Mismatch %s o_setpoint: expected %h actual %h",
                            test_name, {phi_exp, delta_exp}, o_setpoint));
   endtask

   // model steps on the rising edge, outputs checked at the falling edge
   task automatic tick();
      @(posedge ADA_DCO);
      if (i_reset) begin
         reset_reference();
      end else begin
         step_reference(i_panel, i_mosfet_cmd, i_dt_sel);
      end
      @(negedge ADA_DCO);
      check_outputs();
   endtask

   task automatic run_cycles(input int n);
      repeat (n) tick();
   endtask

   task automatic set_buttons(input logic [4:0] mask, input logic level);
      i_panel = level ? (i_panel | mask) : (i_panel & ~mask);
   endtask

   // contact chatter shorter than the debounce window, then a clean hold
   task automatic bounce(input logic [4:0] mask, input logic level);
      int len;
      repeat (3) begin
         rnd = $random(seed);
         len = 1 + int'(rnd[7:0]) % (DEBOUNCE_CYCLES - 1);
         set_buttons(mask, level);
         run_cycles(len);
         set_buttons(mask, ~level);
         run_cycles(len);
      end
      set_buttons(mask, level);
      run_cycles(3 * DEBOUNCE_CYCLES);
   endtask

   // no leg with both switches on
   function automatic logic [3:0] drop_shorts(input logic [3:0] c);
      logic [3:0] r;
      r = c;
      if (r[0] && r[2]) begin
         r[2] = 1'b0;
      end
      if (r[1] && r[3]) begin
         r[3] = 1'b0;
      end
      return r;
   endfunction

   // raise enable and count the start-up patterns seen on o_gate
   task automatic enable_and_count();
      int boot_n;
      int pre_n;
      boot_n = 0;
      pre_n  = 0;
      i_mosfet_cmd   = '0;
      i_panel.enable = 1'b1;
      repeat (STARTUP_LEN) begin
         tick();
         if (o_gate === 4'b1100) begin
            boot_n++;
         end else if (o_gate === 4'b1001) begin
            pre_n++;
         end
      end
      assert (boot_n == ON_CYCLES) else
         fail_run($sformatf("Mismatch %s bootstrap cycles: expected %0d actual %0d",
                            test_name, ON_CYCLES, boot_n));
      assert (pre_n == VG_CYCLES - ON_CYCLES) else
         fail_run($sformatf("Mismatch %s pre-charge cycles: expected %0d actual %0d",
                            test_name, VG_CYCLES - ON_CYCLES, pre_n));
   endtask

   // ========================================
   // watchdog
   // ========================================
   initial begin
      #(TIMEOUT_NS);
      fail_run("Timeout: the tests did not finish before the watchdog expired");
   end

   // ========================================
   // test sequence
   // ========================================
   initial begin : main
      logic [4:0] mask;
      seed         = 32'hb8cb_e6af;
      rnd          = '0;
      ADA_DCO      = 1'b0;
      i_reset      = 1'b1;
      i_panel      = '0;
      i_mosfet_cmd = '0;
      i_dt_sel     = DT_00;
      test_name    = "reset";
      reset_reference();
      run_cycles(8);
      i_reset = 1'b0;

      // bridge disabled, commands must not reach the gates
      repeat (40) begin
         rnd = $random(seed);
         i_mosfet_cmd = rnd[3:0];
         tick();
      end
      i_mosfet_cmd = '0;

      // buttons: enable 4, reset_angles 3, inc_phi 2, dec_phi 1, inc_delta 0
      test_name = "setpoints";
      repeat (N_PRESSES) begin
         rnd = $random(seed);
         case (rnd[2:0])
            3'd0: mask = 5'b01000;
            3'd1, 3'd2: mask = 5'b00100;
            3'd3: mask = 5'b00010;
            // inc and dec together
            3'd4: mask = 5'b00110;
            3'd5, 3'd6: mask = 5'b00001;
            default: mask = 5'b01100;
         endcase
         bounce(mask, 1'b1);
         bounce(mask, 1'b0);
      end

      // push both setpoints against their upper bounds
      repeat (N_SAT_PRESSES) begin
         bounce(5'b00101, 1'b1);
         bounce(5'b00101, 1'b0);
      end

      test_name = "startup";
      enable_and_count();

      // safe command patterns, switch code changes now and then
      test_name = "dead time";
      repeat (DT_LEN) begin
         rnd = $random(seed);
         if (rnd[5:0] == 6'd0) begin
            i_mosfet_cmd = drop_shorts(rnd[11:8]);
         end
         if (rnd[15:12] == 4'd0) begin
            i_dt_sel = dt_sel_e'(rnd[17:16]);
         end
         tick();
      end

      // one leg shorted while a switch of the other leg is on, or both legs shorted
      test_name = "shoot-through";
      repeat (4) begin
         rnd = $random(seed);
         i_dt_sel     = dt_sel_e'(rnd[3:2]);
         i_mosfet_cmd = 4'b1001;
         run_cycles(SHORT_LEN);
         i_mosfet_cmd = rnd[0] ? 4'b0111 : (rnd[1] ? 4'b1011 : 4'b1111);
         run_cycles(SHORT_LEN);
         assert (o_gate === 4'b0000) else
            fail_run($sformatf("Mismatch %s o_gate: expected 0000 actual %b",
                               test_name, o_gate));
      end

      // drop the enable with chatter, then start over
      test_name    = "disable";
      i_mosfet_cmd = 4'b1001;
      run_cycles(SHORT_LEN);
      bounce(5'b10000, 1'b0);
      assert (o_gate === 4'b0000) else
         fail_run($sformatf("Mismatch %s o_gate: expected 0000 actual %b",
                            test_name, o_gate));
      enable_and_count();

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: hb_gate_top.f
+incdir+tests
common/hb_pkg.sv
source/panel_debounce.sv
setpoint/setpoint_register.sv
gate_path/startup_sequencer.sv
gate_path/dead_time.sv
gate_path/gate_driver.sv
source/hb_gate_top.sv
tests/tb_hb_gate_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
   --timescale 1ns/1ps \
   --top-module tb_hb_gate_top \
   -f hb_gate_top.f \
   -o sim_tb
# a $fatal in the testbench gives a failing exit status
./obj_dir/sim_tb
